// ==== hw/cav_pkg.sv ====
package cav_pkg;

	// Drive samples and coupling magnitudes are signed words of this width
	localparam int sample_w = 18;

	// One full turn of phase spans 2**phase_w counts
	// The pair output uses the same width because it keeps one bit above a sample
	localparam int phase_w = 19;

	// Host register map
	localparam int reg_addr_w = 3;
	localparam logic [reg_addr_w-1:0] reg_coup0 = reg_addr_w'(0);
	localparam logic [reg_addr_w-1:0] reg_coup1 = reg_addr_w'(1);
	localparam logic [reg_addr_w-1:0] reg_off0 = reg_addr_w'(2);
	localparam logic [reg_addr_w-1:0] reg_off1 = reg_addr_w'(3);
	localparam logic [reg_addr_w-1:0] reg_freq = reg_addr_w'(4);
	// Addresses 5 to 7 hold nothing and read back as zero

	// Gain of the unrolled CORDIC in unsigned Q1.16
	// The product of sqrt(1 + 2**-2i) has settled at 1.64676 well before twenty stages
	// A coupling magnitude above about 79500 therefore wraps in the 18-bit rotator output
	localparam int cordic_gain_q = 107922;

endpackage

// ==== hw/coupling_if.sv ====
// Coupling lookup between the register bank and the coupling pipeline
// Both selects are plain one-bit channel numbers and the bank answers in the same cycle
interface coupling_if;
	import cav_pkg::*;

	// Channel whose magnitude goes into the rotator this cycle
	logic coup_sel;
	logic signed [sample_w-1:0] coupling;

	// Channel whose phase offset gets added to the LO phase this cycle
	logic off_sel;
	logic [phase_w-1:0] phase_offset;

	modport bank (
		input coup_sel,
		input off_sel,
		output coupling,
		output phase_offset
	);

	modport pipe (
		output coup_sel,
		output off_sel,
		input coupling,
		input phase_offset
	);

endinterface

// ==== hw/cordic_rotate.sv ====
// Fully unrolled rotation-mode CORDIC
// The output vector is the input rotated by phase and scaled by cav_pkg::cordic_gain_q
// Latency is nstg + 2 cycles with one new vector accepted every cycle
module cordic_rotate #(
	parameter int nstg = 20,
	parameter int width = 18
) (
	input logic clk,
	input logic rst_n,
	input logic signed [width-1:0] xin,
	input logic signed [width-1:0] yin,
	input logic [cav_pkg::phase_w-1:0] phase,
	output logic signed [width-1:0] xout,
	output logic signed [width-1:0] yout
);
	import cav_pkg::*;

	// Fraction bits kept below the output LSB to soak up shift truncation
	localparam int fb = 4;
	// Two extra integer bits cover the gain and the quadrant negation
	localparam int iw = width + 2 + fb;
	// The angle residual carries extra fraction bits so late arctangents stay nonzero
	localparam int zfrac = 3;
	localparam int zw = phase_w + zfrac;

	// Arctangent of 2**-i in units of one turn divided by 2**zw
	// Only ever evaluated at elaboration to fill the per-stage constants
	function automatic logic signed [zw-1:0] atan_q(input int i);
		real a;
		a = $atan(2.0 ** (-i)) / (2.0 * 3.14159265358979);
		return zw'($rtoi(a * (2.0 ** zw) + 0.5));
	endfunction

	logic signed [iw-1:0] xw;
	logic signed [iw-1:0] yw;
	logic signed [iw-1:0] xs [nstg+1];
	logic signed [iw-1:0] ys [nstg+1];
	logic signed [zw-1:0] zs [nstg];

	assign xw = {{2{xin[width-1]}}, xin, {fb{1'b0}}};
	assign yw = {{2{yin[width-1]}}, yin, {fb{1'b0}}};

	// The top two phase bits pick a quarter turn applied exactly by swap and negate
	// What is left lies in [0, 90) degrees, inside the 99.9 degree reach of the stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xs[0] <= '0;
			ys[0] <= '0;
			zs[0] <= '0;
		end else begin
			case (phase[phase_w-1 -: 2])
				2'd0: begin
					xs[0] <= xw;
					ys[0] <= yw;
				end
				2'd1: begin
					xs[0] <= -yw;
					ys[0] <= xw;
				end
				2'd2: begin
					xs[0] <= -xw;
					ys[0] <= -yw;
				end
				default: begin
					xs[0] <= yw;
					ys[0] <= -xw;
				end
			endcase
			zs[0] <= {2'b00, phase[phase_w-3:0], {zfrac{1'b0}}};
		end
	end

	// Each stage turns the vector by plus or minus atan(2**-s) toward zero residual
	for (genvar s = 0; s < nstg; s++) begin : g_stage
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				xs[s+1] <= '0;
				ys[s+1] <= '0;
			end else if (zs[s][zw-1]) begin
				xs[s+1] <= xs[s] + (ys[s] >>> s);
				ys[s+1] <= ys[s] - (xs[s] >>> s);
			end else begin
				xs[s+1] <= xs[s] - (ys[s] >>> s);
				ys[s+1] <= ys[s] + (xs[s] >>> s);
			end
		end

		// The last stage only needs the sign of its residual, so no angle follows it
		if (s < nstg - 1) begin : g_ang
			localparam logic signed [zw-1:0] step = atan_q(s);

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					zs[s+1] <= '0;
				end else if (zs[s][zw-1]) begin
					zs[s+1] <= zs[s] + step;
				end else begin
					zs[s+1] <= zs[s] - step;
				end
			end
		end
	end

	// Round half up back to the sample grid and drop the guard bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xout <= '0;
			yout <= '0;
		end else begin
			xout <= xs[nstg][fb +: width] + width'(xs[nstg][fb-1]);
			yout <= ys[nstg][fb +: width] + width'(ys[nstg][fb-1]);
		end
	end

endmodule

// ==== hw/lo_phase_gen.sv ====
// Local oscillator phase source for the interleaved stream
// iq marks I when high and Q when low and flips on every clock after reset
// The phase accumulator steps once per I/Q pair so both halves of a pair see one phase
module lo_phase_gen (
	input logic clk,
	input logic rst_n,
	input logic [cav_pkg::phase_w-1:0] freq,
	output logic iq,
	output logic [cav_pkg::phase_w-1:0] lo_phase
);

	// iq sits low through reset, so the first cycle after release is an I cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iq <= 1'b0;
		end else begin
			iq <= ~iq;
		end
	end

	// Advance at the end of each Q cycle
	// The new phase then holds through the following I and Q cycles
	// Overflow wraps modulo one turn, which is exactly what a phase needs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lo_phase <= '0;
		end else if (!iq) begin
			lo_phase <= lo_phase + freq;
		end
	end

endmodule

// ==== hw/coupling_regs.sv ====
// Host register bank for the two output couplings and the LO frequency
// Host writes land on the next clock edge and the host read port is combinational
// The pipeline has its own combinational lookup port, so host traffic never stalls it
module coupling_regs (
	input logic clk,
	input logic rst_n,
	input logic host_we,
	input logic [cav_pkg::reg_addr_w-1:0] host_addr,
	input logic [cav_pkg::phase_w-1:0] host_wdata,
	output logic [cav_pkg::phase_w-1:0] host_rdata,
	output logic [cav_pkg::phase_w-1:0] freq,
	coupling_if.bank cpl
);
	import cav_pkg::*;

	// Every register keeps the full host word so readback returns what was written
	// Only the low sample_w bits of a coupling reach the rotator
	logic [phase_w-1:0] coup_q [2];
	logic [phase_w-1:0] off_q [2];
	logic [phase_w-1:0] freq_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			coup_q[0] <= '0;
			coup_q[1] <= '0;
			off_q[0] <= '0;
			off_q[1] <= '0;
			freq_q <= '0;
		end else if (host_we) begin
			case (host_addr)
				reg_coup0: coup_q[0] <= host_wdata;
				reg_coup1: coup_q[1] <= host_wdata;
				reg_off0: off_q[0] <= host_wdata;
				reg_off1: off_q[1] <= host_wdata;
				reg_freq: freq_q <= host_wdata;
				// Writes to the spare addresses are dropped
				default: ;
			endcase
		end
	end

	always_comb begin
		case (host_addr)
			reg_coup0: host_rdata = coup_q[0];
			reg_coup1: host_rdata = coup_q[1];
			reg_off0: host_rdata = off_q[0];
			reg_off1: host_rdata = off_q[1];
			reg_freq: host_rdata = freq_q;
			default: host_rdata = '0;
		endcase
	end

	// Pipeline lookups answered in the same cycle as the select
	assign cpl.coupling = coup_q[cpl.coup_sel][sample_w-1:0];
	assign cpl.phase_offset = off_q[cpl.off_sel];
	assign freq = freq_q;

endmodule

// ==== hw/pair_couple.sv ====
// Applies a pair of complex couplings to an interleaved I/Q drive
// Each output sample is Re(drive * coupling) for channel 0 and channel 1 in turn
// Only two multipliers are used and the rotator dominates the area
module pair_couple #(
	parameter int nstg = 20
) (
	input logic clk,
	input logic rst_n,
	input logic iq,
	input logic signed [cav_pkg::sample_w-1:0] drive,
	input logic [cav_pkg::phase_w-1:0] lo_phase,
	output logic signed [cav_pkg::phase_w-1:0] pair,
	coupling_if.pipe cpl
);
	import cav_pkg::*;

	// Rotator latency, which the drive path must match
	localparam int dly = nstg + 2;

	logic [phase_w-1:0] out_phase;
	logic signed [sample_w-1:0] xout;
	logic signed [sample_w-1:0] yout;
	logic signed [sample_w-1:0] drive_dly [dly];
	logic iq_dly [dly];
	logic signed [sample_w-1:0] drive1;
	logic signed [sample_w-1:0] d_real;
	logic signed [sample_w-1:0] d_imag;
	logic signed [2*sample_w-1:0] prodx;
	logic signed [2*sample_w-1:0] prody;
	logic signed [sample_w-1:0] prodxs;
	logic signed [sample_w-1:0] prodys;
	logic signed [sample_w-1:0] prodx2;
	logic signed [sample_w-1:0] prody2;

	// Magnitude goes straight to the rotator while the phase passes through out_phase
	// Selecting the offset with ~iq one cycle early lines both up on the same channel
	// Channel 0 enters the rotator on Q cycles and channel 1 on I cycles
	assign cpl.coup_sel = iq;
	assign cpl.off_sel = ~iq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_phase <= '0;
		end else begin
			out_phase <= lo_phase + cpl.phase_offset;
		end
	end

	// Coupling vector from magnitude and total phase
	cordic_rotate #(
		.nstg(nstg),
		.width(sample_w)
	) u_cordic (
		.clk(clk),
		.rst_n(rst_n),
		.xin(cpl.coupling),
		.yin('0),
		.phase(out_phase),
		.xout(xout),
		.yout(yout)
	);

	// Hold drive and its I/Q marker back by the rotator latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dly; i++) begin
				drive_dly[i] <= '0;
				iq_dly[i] <= 1'b0;
			end
		end else begin
			drive_dly[0] <= drive;
			iq_dly[0] <= iq;
			for (int i = 1; i < dly; i++) begin
				drive_dly[i] <= drive_dly[i-1];
				iq_dly[i] <= iq_dly[i-1];
			end
		end
	end

	// Q arrives first and I follows, so the complex pair is latched on the I sample
	// d_real and d_imag then stay steady for the two cycles that serve both channels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive1 <= '0;
			d_real <= '0;
			d_imag <= '0;
		end else begin
			drive1 <= drive_dly[dly-1];
			if (iq_dly[dly-1]) begin
				d_real <= drive_dly[dly-1];
				d_imag <= drive1;
			end
		end
	end

	// Real part of the complex product, scaled back by 2**17
	assign prodxs = prodx[2*sample_w-2:sample_w-1];
	assign prodys = prody[2*sample_w-2:sample_w-1];

	// The difference keeps its extra MSB and is left unsaturated for a later sum
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prodx <= '0;
			prody <= '0;
			prodx2 <= '0;
			prody2 <= '0;
			pair <= '0;
		end else begin
			prodx <= xout * d_real;
			prody <= yout * d_imag;
			prodx2 <= prodxs;
			prody2 <= prodys;
			pair <= phase_w'(prodx2) - phase_w'(prody2);
		end
	end

endmodule

// ==== hw/cav_couple_top.sv ====
// Output coupling model of the cavity simulator
// The drive stream arrives interleaved at twice the ADC rate with iq telling I from Q
// pair shows channel 0 on cycles where iq is high and channel 1 where iq is low
// An I sample shows up in pair nstg + 6 cycles after it is presented
module cav_couple_top #(
	parameter int nstg = 20
) (
	input logic clk,
	input logic rst_n,
	input logic host_we,
	input logic [cav_pkg::reg_addr_w-1:0] host_addr,
	input logic [cav_pkg::phase_w-1:0] host_wdata,
	input logic signed [cav_pkg::sample_w-1:0] drive,
	output logic [cav_pkg::phase_w-1:0] host_rdata,
	output logic iq,
	output logic signed [cav_pkg::phase_w-1:0] pair
);
	import cav_pkg::*;

	logic [phase_w-1:0] freq;
	logic [phase_w-1:0] lo_phase;

	// Lookup path from the pipeline into the register bank
	coupling_if cpl ();

	// LO phase and the I/Q strobe the outside world follows
	lo_phase_gen u_lo (
		.clk(clk),
		.rst_n(rst_n),
		.freq(freq),
		.iq(iq),
		.lo_phase(lo_phase)
	);

	coupling_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.freq(freq),
		.cpl(cpl)
	);

	pair_couple #(
		.nstg(nstg)
	) u_pair (
		.clk(clk),
		.rst_n(rst_n),
		.iq(iq),
		.drive(drive),
		.lo_phase(lo_phase),
		.pair(pair),
		.cpl(cpl)
	);

endmodule

// ==== bench/cav_couple_props.sv ====
// Concurrent checks on the coupling pipeline
// iq and lo_phase come straight from lo_phase_gen, so the phase source is watched here too
module cav_couple_props #(
	parameter int nstg = 20
) (
	input logic clk,
	input logic rst_n,
	input logic iq,
	input logic [cav_pkg::phase_w-1:0] lo_phase,
	input logic coup_sel,
	input logic signed [cav_pkg::phase_w-1:0] pair
);
	timeunit 1ns;
	timeprecision 1ps;

	// Edges seen since reset, saturating well past the pipeline depth
	logic [7:0] run_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_cnt <= '0;
		end else if (run_cnt != 8'hff) begin
			run_cnt <= run_cnt + 8'd1;
		end
	end

	iq_toggles: assert property (@(posedge clk) disable iff (!rst_n)
		run_cnt != 0 |-> iq != $past(iq))
		else $error("iq held its value for two cycles");

	// The accumulator only moves on the edge that ends a Q cycle
	lo_steps_after_q: assert property (@(posedge clk) disable iff (!rst_n)
		run_cnt != 0 && $past(iq) |-> $stable(lo_phase))
		else $error("lo_phase moved after an I cycle");

	coup_sel_follows_iq: assert property (@(posedge clk) disable iff (!rst_n)
		coup_sel == iq)
		else $error("coupling select differs from iq");

	pair_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		run_cnt < nstg + 6 |-> pair == '0)
		else $error("pair left zero before the pipeline could fill");

endmodule

bind pair_couple cav_couple_props #(
	.nstg(nstg)
) u_props (
	.clk(clk),
	.rst_n(rst_n),
	.iq(iq),
	.lo_phase(lo_phase),
	.coup_sel(cpl.coup_sel),
	.pair(pair)
);

// ==== bench/cav_couple_tb.sv ====
// Random-stimulus testbench for the cavity output couplings
// A cycle-level model tracks iq, the LO phase and the host registers
// Each I sample queues the two coupled outputs it should produce later
module cav_couple_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cav_pkg::*;

	localparam int nstg = 20;
	// From an I sample to its channel 0 output, channel 1 comes one cycle later
	localparam int lat = nstg + 6;
	localparam int tol = 8;
	localparam real gain = real'(cordic_gain_q) / 65536.0;

	logic clk;
	logic rst_n;
	logic host_we;
	logic [reg_addr_w-1:0] host_addr;
	logic [phase_w-1:0] host_wdata;
	logic signed [sample_w-1:0] drive;
	logic [phase_w-1:0] host_rdata;
	logic iq;
	logic signed [phase_w-1:0] pair;

	// Model state, advanced once per rising edge
	logic [31:0] rnd_state;
	int cyc;
	logic m_iq;
	logic [phase_w-1:0] m_lo;
	// Spare addresses 5 to 7 are never written and stay zero
	logic [phase_w-1:0] m_reg [8];
	logic p_we;
	logic [reg_addr_w-1:0] p_addr;
	logic [phase_w-1:0] p_wdata;
	int drv_prev;
	bit chk_on;
	bit quarter;

	// Expected pair values, each tagged with the cycle it belongs to
	int exp_cyc [$];
	real exp_val [$];
	bit exp_exact [$];

	cav_couple_top #(
		.nstg(nstg)
	) cav_couple_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.drive(drive),
		.host_rdata(host_rdata),
		.iq(iq),
		.pair(pair)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rnd_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rnd_state = x;
		return x;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = xorshift();
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	function automatic logic [phase_w-1:0] rand_phase();
		return phase_w'(xorshift());
	endfunction

	function automatic logic signed [sample_w-1:0] rand_drive();
		return sample_w'(xorshift());
	endfunction

	// Re(gain * mag * exp(j*theta) * (d_re + j*d_im)) scaled down by 2**17
	function automatic real ideal_pair(input int mag, input logic [phase_w-1:0] ph,
			input int d_re, input int d_im);
		real th;
		th = 2.0 * 3.14159265358979 * real'(ph) / (2.0 ** phase_w);
		return gain * real'(mag) * ($cos(th) * real'(d_re) - $sin(th) * real'(d_im))
			/ (2.0 ** (sample_w - 1));
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic queue_expected(input int d_re, input int d_im);
		int mag0;
		int mag1;
		real v0;
		mag0 = int'(signed'(m_reg[reg_coup0][sample_w-1:0]));
		mag1 = int'(signed'(m_reg[reg_coup1][sample_w-1:0]));
		// With a quarter turn and the LO at zero channel 0 reduces to minus the imaginary part
		if (quarter) begin
			v0 = -gain * real'(mag0) * real'(d_im) / (2.0 ** (sample_w - 1));
		end else begin
			v0 = ideal_pair(mag0, phase_w'(m_lo + m_reg[reg_off0]), d_re, d_im);
		end
		exp_cyc.push_back(cyc + lat);
		exp_val.push_back(v0);
		exp_exact.push_back(mag0 == 0);
		exp_cyc.push_back(cyc + lat + 1);
		exp_val.push_back(ideal_pair(mag1, phase_w'(m_lo + m_reg[reg_off1]), d_re, d_im));
		exp_exact.push_back(mag1 == 0);
	endtask

	// Runs at the falling edge where every DUT output has settled
	task automatic check_cycle();
		real diff;
		assert (iq === m_iq)
			else report_error($sformatf("mismatch at %0t: iq expected %0b got %0b",
				$time, m_iq, iq));
		assert (host_rdata === m_reg[p_addr])
			else report_error($sformatf("mismatch at %0t: host_rdata expected %0h got %0h",
				$time, m_reg[p_addr], host_rdata));
		while (exp_cyc.size() > 0 && exp_cyc[0] <= cyc) begin
			diff = real'(pair) - exp_val[0];
			if (exp_exact[0]) begin
				assert (pair === '0)
					else report_error($sformatf("mismatch at %0t: pair expected 0 got %0d",
						$time, pair));
			end else begin
				assert (diff <= tol && diff >= -tol)
					else report_error($sformatf("mismatch at %0t: pair expected %0.1f got %0d",
						$time, exp_val[0], pair));
			end
			void'(exp_cyc.pop_front());
			void'(exp_val.pop_front());
			void'(exp_exact.pop_front());
		end
	endtask

	task automatic next_cycle(input logic we, input logic [reg_addr_w-1:0] addr,
			input logic [phase_w-1:0] wdata, input logic signed [sample_w-1:0] d);
		@(posedge clk);
		// The LO steps after a Q cycle with the frequency held before any write on this edge
		if (!m_iq) begin
			m_lo = m_lo + m_reg[reg_freq];
		end
		if (p_we && p_addr <= reg_freq) begin
			m_reg[p_addr] = p_wdata;
		end
		m_iq = ~m_iq;
		cyc++;
		host_we <= we;
		host_addr <= addr;
		host_wdata <= wdata;
		drive <= d;
		p_we = we;
		p_addr = addr;
		p_wdata = wdata;
		// An I sample closes a drive pair whose Q half came one cycle earlier
		if (chk_on && m_iq) begin
			queue_expected(int'(d), drv_prev);
		end
		drv_prev = int'(d);
		@(negedge clk);
		check_cycle();
	endtask

	task automatic idle();
		logic [31:0] r;
		r = xorshift();
		next_cycle(1'b0, r[reg_addr_w-1:0], '0, rand_drive());
	endtask

	task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [phase_w-1:0] data);
		next_cycle(1'b1, addr, data, rand_drive());
	endtask

	// Magnitudes stay below the point where the rotator output would wrap
	task automatic load_couplings(input bit qturn, input bit mute0, input bit mute1,
			input bit spin);
		int m0;
		int m1;
		m0 = rand_range(-70000, 70000);
		m1 = rand_range(-70000, 70000);
		write_reg(reg_coup0, mute0 ? '0 : phase_w'(m0));
		write_reg(reg_coup1, mute1 ? '0 : phase_w'(m1));
		write_reg(reg_off0, qturn ? phase_w'(1 << (phase_w - 2)) : rand_phase());
		write_reg(reg_off1, rand_phase());
		write_reg(reg_freq, spin ? rand_phase() : '0);
		quarter = qturn;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_cyc.size() > 0 && waited < 2 * lat) begin
			idle();
			waited++;
		end
		assert (exp_cyc.size() == 0)
			else report_error("timed out waiting for the queued pair outputs");
	endtask

	task automatic checked_run(input int n);
		chk_on = 1'b1;
		repeat (n) idle();
		chk_on = 1'b0;
		drain();
	endtask

	initial begin
		logic [31:0] r;
		rnd_state = 32'he78e4dff;
		rst_n = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		drive = '0;
		cyc = 0;
		m_iq = 1'b0;
		m_lo = '0;
		p_we = 1'b0;
		p_addr = '0;
		p_wdata = '0;
		drv_prev = 0;
		chk_on = 1'b0;
		quarter = 1'b0;
		for (int i = 0; i < 8; i++) begin
			m_reg[i] = '0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_cycle();
		assert (pair === '0)
			else report_error($sformatf("mismatch at %0t: pair expected 0 got %0d", $time, pair));

		// All couplings are still zero, so pair must stay quiet while iq starts at 1
		repeat (lat + 4) begin
			idle();
			assert (pair === '0)
				else report_error($sformatf("mismatch at %0t: pair expected 0 got %0d",
					$time, pair));
		end

		// Frequency still zero since reset, so the LO phase is parked at zero
		load_couplings(1'b1, 1'b0, 1'b0, 1'b0);
		checked_run(80);
		quarter = 1'b0;

		// Write then read back every address, spare ones included
		for (int a = 0; a < 8; a++) begin
			write_reg(reg_addr_w'(a), rand_phase());
			next_cycle(1'b0, reg_addr_w'(a), '0, rand_drive());
		end
		repeat (40) begin
			r = xorshift();
			next_cycle(r[0], r[3:1], r[31:13], rand_drive());
		end

		repeat (3) begin
			load_couplings(1'b0, 1'b0, 1'b0, 1'b0);
			checked_run(80);
		end
		repeat (3) begin
			load_couplings(1'b0, 1'b0, 1'b0, 1'b1);
			checked_run(80);
		end

		// One channel muted at a time while the LO keeps turning
		load_couplings(1'b0, 1'b1, 1'b0, 1'b1);
		checked_run(60);
		load_couplings(1'b0, 1'b0, 1'b1, 1'b1);
		checked_run(60);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/cav_pkg.sv
hw/coupling_if.sv
hw/cordic_rotate.sv
hw/lo_phase_gen.sv
hw/coupling_regs.sv
hw/pair_couple.sv
hw/cav_couple_top.sv
bench/cav_couple_props.sv
bench/cav_couple_tb.sv

// ==== Bender.yml ====
package:
  name: cav_couple

sources:
  - files:
      - hw/cav_pkg.sv
      - hw/coupling_if.sv
      - hw/cordic_rotate.sv
      - hw/lo_phase_gen.sv
      - hw/coupling_regs.sv
      - hw/pair_couple.sv
      - hw/cav_couple_top.sv
  - target: test
    files:
      - bench/cav_couple_props.sv
      - bench/cav_couple_tb.sv
